// File: include/ic_params.svh
`ifndef IC_PARAMS_SVH
`define IC_PARAMS_SVH

// Address and data widths
`define IC_ADR_W        32
`define IC_WORD_W       32

// Line geometry, four words of four bytes
`define IC_BEATS        4
`define IC_OFS_W        4
`define IC_L1_LINES     16
`define IC_L1_IDX_W     4
`define IC_L2_LINES     32
`define IC_L2_IDX_W     5

// Latencies in clk cycles
`define IC_L2_LATENCY   2
`define IC_ROM_LATENCY  1
`define IC_L1_WR_LATENCY 3

// Boot ROM decode, top 1 MiB of the address space
`define IC_ROM_HI_W     12
`define IC_ROM_BASE_HI  12'hFFF

// Filler word for lines that took a bus error
`define IC_NOP          32'h0000_0013

`endif

// File: hdl/ic_cache_pkg.sv
`default_nettype none

`include "ic_params.svh"

package ic_cache_pkg;

	// Byte address as seen by the fetch port
	typedef logic [`IC_ADR_W-1:0] adr_t;

	// One instruction word
	typedef logic [`IC_WORD_W-1:0] word_t;

	// Whole line, word 0 in the low bits
	typedef logic [`IC_BEATS*`IC_WORD_W-1:0] line_t;

	// Free running event counter
	typedef logic [31:0] ctr_t;

	// Miss controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WAIT_L2,
		BUS_ACK,
		BUS_GAP,
		BUS_DONE,
		WR_WAIT
	} miss_state_e;

endpackage

`default_nettype wire

// File: hdl/ic_bus_pkg.sv
`default_nettype none

`include "ic_params.svh"

package ic_bus_pkg;

	// Word address driven on the bus
	typedef logic [`IC_ADR_W-3:0] wadr_t;

	// Beat number inside a line transfer
	typedef logic [$clog2(`IC_BEATS)-1:0] beat_t;

	// Cycle type identifier
	typedef logic [2:0] cti_t;

	localparam cti_t CTI_CLASSIC = 3'b000;
	localparam cti_t CTI_INCR    = 3'b010;
	localparam cti_t CTI_END     = 3'b111;

	// Fault code stored with each L1 line
	typedef enum logic [1:0] {
		FAULT_NONE = 2'b00,
		FAULT_BUS  = 2'b01
	} fault_e;

endpackage

`default_nettype wire

// File: hdl/ic_boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module ic_boot_rom (
	input  wire                       clk,
	input  wire                       rd_i,
	input  wire  ic_cache_pkg::adr_t  adr_i,
	output ic_cache_pkg::line_t       line_o
);

	localparam int W = `IC_WORD_W;

	// Content pattern mixed into each word address
	localparam ic_cache_pkg::word_t ROM_KEY = 32'h5A5A_0000;

	// Whole line read in one cycle
	always_ff @(posedge clk) begin
		if (rd_i) begin
			for (int i = 0; i < `IC_BEATS; i++)
				line_o[i*W +: W] <= ic_cache_pkg::word_t'({adr_i[`IC_ADR_W-1:`IC_OFS_W],
					ic_bus_pkg::beat_t'(i)}) ^ ROM_KEY;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ic_l1_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module ic_l1_array (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire  ic_cache_pkg::adr_t   rd_adr_i,
	output logic                       hit_o,
	output ic_cache_pkg::word_t        insn_o,
	output ic_bus_pkg::fault_e         fault_o,
	input  wire                        wr_i,
	input  wire  ic_cache_pkg::adr_t   wr_adr_i,
	input  wire  ic_cache_pkg::line_t  wr_line_i,
	input  wire  ic_bus_pkg::fault_e   wr_fault_i,
	input  wire                        inval_i
);

	localparam int IDX_W   = `IC_L1_IDX_W;
	localparam int TAG_LSB = `IC_OFS_W + IDX_W;
	localparam int TAG_W   = `IC_ADR_W - TAG_LSB;
	localparam int W       = `IC_WORD_W;

	logic [`IC_L1_LINES-1:0] valid;
	logic [TAG_W-1:0]        tag_mem   [`IC_L1_LINES];
	ic_bus_pkg::fault_e      fault_mem [`IC_L1_LINES];
	ic_cache_pkg::line_t     data_mem  [`IC_L1_LINES];

	logic [IDX_W-1:0]    rd_idx;
	logic [IDX_W-1:0]    wr_idx;
	logic [TAG_W-1:0]    rd_tag;
	logic [TAG_W-1:0]    wr_tag;
	ic_bus_pkg::beat_t   rd_word;
	ic_cache_pkg::line_t rd_line;

	// Address split for both ports
	assign rd_idx  = rd_adr_i[`IC_OFS_W +: IDX_W];
	assign rd_tag  = rd_adr_i[`IC_ADR_W-1:TAG_LSB];
	assign rd_word = rd_adr_i[2 +: $bits(ic_bus_pkg::beat_t)];
	assign wr_idx  = wr_adr_i[`IC_OFS_W +: IDX_W];
	assign wr_tag  = wr_adr_i[`IC_ADR_W-1:TAG_LSB];

	// Lookup is purely combinational
	assign rd_line = data_mem[rd_idx];
	assign hit_o   = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign insn_o  = rd_line[rd_word*W +: W];
	assign fault_o = fault_mem[rd_idx];

	// Valid bits, invalidate only on a tag match
	always_ff @(posedge clk) begin
		if (rst_i)
			valid <= '0;
		else if (wr_i)
			valid[wr_idx] <= 1'b1;
		else if (inval_i && tag_mem[wr_idx] == wr_tag)
			valid[wr_idx] <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_idx]   <= wr_tag;
			fault_mem[wr_idx] <= wr_fault_i;
			data_mem[wr_idx]  <= wr_line_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ic_l2_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module ic_l2_array (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire                        rd_i,
	input  wire  ic_cache_pkg::adr_t   rd_adr_i,
	output logic                       valid_o,
	output ic_cache_pkg::line_t        line_o,
	input  wire                        wr_i,
	input  wire  ic_cache_pkg::adr_t   wr_adr_i,
	input  wire  ic_cache_pkg::line_t  wr_line_i
);

	localparam int IDX_W   = `IC_L2_IDX_W;
	localparam int TAG_LSB = `IC_OFS_W + IDX_W;
	localparam int TAG_W   = `IC_ADR_W - TAG_LSB;
	localparam int LAT     = `IC_L2_LATENCY;

	logic [`IC_L2_LINES-1:0] valid;
	logic [TAG_W-1:0]        tag_mem  [`IC_L2_LINES];
	ic_cache_pkg::line_t     data_mem [`IC_L2_LINES];

	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// Read pipe, one entry per stage
	logic [LAT-1:0]      vld_q;
	logic [TAG_W-1:0]    tag_q  [LAT];
	logic [TAG_W-1:0]    req_q  [LAT];
	ic_cache_pkg::line_t line_q [LAT];

	assign rd_idx = rd_adr_i[`IC_OFS_W +: IDX_W];
	assign wr_idx = wr_adr_i[`IC_OFS_W +: IDX_W];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
			vld_q <= '0;
		end else begin
			if (wr_i)
				valid[wr_idx] <= 1'b1;
			vld_q[0] <= rd_i && valid[rd_idx];
			for (int i = 1; i < LAT; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	// Stage 0 reads the arrays, later stages only shift
	always_ff @(posedge clk) begin
		tag_q[0]  <= tag_mem[rd_idx];
		req_q[0]  <= rd_adr_i[`IC_ADR_W-1:TAG_LSB];
		line_q[0] <= data_mem[rd_idx];
		for (int i = 1; i < LAT; i++) begin
			tag_q[i]  <= tag_q[i-1];
			req_q[i]  <= req_q[i-1];
			line_q[i] <= line_q[i-1];
		end
		if (wr_i) begin
			tag_mem[wr_idx]  <= wr_adr_i[`IC_ADR_W-1:TAG_LSB];
			data_mem[wr_idx] <= wr_line_i;
		end
	end

	// Tag compare in the last stage
	assign valid_o = vld_q[LAT-1] && (tag_q[LAT-1] == req_q[LAT-1]);
	assign line_o  = line_q[LAT-1];

endmodule

`default_nettype wire

// File: hdl/ic_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module ic_ctrl_regs (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire                        cfg_we_i,
	input  wire  [1:0]                 cfg_addr_i,
	input  wire  ic_cache_pkg::word_t  cfg_wdata_i,
	output ic_cache_pkg::word_t        cfg_rdata_o,
	output logic                       burst_en_o,
	output logic                       inval_o,
	output ic_cache_pkg::adr_t         inval_adr_o,
	input  wire                        line_loaded_i
);

	// Register map
	localparam logic [1:0] REG_CFG   = 2'd0;
	localparam logic [1:0] REG_INVAL = 2'd1;
	localparam logic [1:0] REG_LOADS = 2'd2;

	ic_cache_pkg::ctr_t load_ctr;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			burst_en_o <= 1'b1;
			inval_o    <= 1'b0;
			load_ctr   <= '0;
		end else begin
			inval_o <= 1'b0;
			if (cfg_we_i && cfg_addr_i == REG_CFG)
				burst_en_o <= cfg_wdata_i[0];
			// Write data is the address to drop
			if (cfg_we_i && cfg_addr_i == REG_INVAL) begin
				inval_o     <= 1'b1;
				inval_adr_o <= cfg_wdata_i;
			end
			if (line_loaded_i)
				load_ctr <= load_ctr + 1'b1;
		end
	end

	// Read mux
	always_comb begin
		case (cfg_addr_i)
		REG_CFG:   cfg_rdata_o = {{(`IC_WORD_W-1){1'b0}}, burst_en_o};
		REG_INVAL: cfg_rdata_o = inval_adr_o;
		REG_LOADS: cfg_rdata_o = load_ctr;
		default:   cfg_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/ic_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module ic_miss_ctrl (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire                        fetch_req_i,
	input  wire  ic_cache_pkg::adr_t   fetch_adr_i,
	input  wire                        l1_hit_i,
	input  wire                        burst_en_i,
	input  wire                        inval_i,
	input  wire  ic_cache_pkg::adr_t   inval_adr_i,
	output logic                       l1_wr_o,
	output logic                       l1_inval_o,
	output ic_cache_pkg::adr_t         l1_adr_o,
	output ic_cache_pkg::line_t        l1_line_o,
	output ic_bus_pkg::fault_e         l1_fault_o,
	output logic                       l2_rd_o,
	output logic                       l2_wr_o,
	output ic_cache_pkg::adr_t         l2_adr_o,
	output ic_cache_pkg::line_t        l2_line_o,
	input  wire                        l2_valid_i,
	input  wire  ic_cache_pkg::line_t  l2_line_i,
	output logic                       rom_rd_o,
	input  wire  ic_cache_pkg::line_t  rom_line_i,
	output logic                       line_loaded_o,
	output logic                       busy_o,
	output logic                       bus_cyc_o,
	output logic                       bus_stb_o,
	output ic_bus_pkg::wadr_t          bus_adr_o,
	output ic_bus_pkg::cti_t           bus_cti_o,
	input  wire                        bus_ack_i,
	input  wire                        bus_err_i,
	input  wire  ic_cache_pkg::word_t  bus_dat_i
);

	localparam int W = `IC_WORD_W;

	ic_cache_pkg::miss_state_e state;
	logic [2:0]                cnt;
	logic                      is_rom;
	logic                      l2_hit_r;
	logic                      burst_r;
	ic_bus_pkg::beat_t         beat;
	logic                      inval_pend;
	ic_cache_pkg::adr_t        inval_adr_r;
	ic_cache_pkg::line_t       line_r;
	ic_cache_pkg::adr_t        fetch_line;
	logic                      rom_sel;

	// Line aligned miss address
	assign fetch_line = {fetch_adr_i[`IC_ADR_W-1:`IC_OFS_W], {`IC_OFS_W{1'b0}}};

	// Top address bits pick the boot ROM
	assign rom_sel = fetch_adr_i[`IC_ADR_W-1 -: `IC_ROM_HI_W] == `IC_ROM_BASE_HI;

	// One line register feeds both cache writes
	assign l1_line_o = line_r;
	assign l2_line_o = line_r;

	assign busy_o = state != ic_cache_pkg::IDLE;

	// ======================================================================
	// Miss FSM
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state         <= ic_cache_pkg::IDLE;
			cnt           <= '0;
			is_rom        <= 1'b0;
			l2_hit_r      <= 1'b0;
			burst_r       <= 1'b0;
			beat          <= '0;
			inval_pend    <= 1'b0;
			l1_wr_o       <= 1'b0;
			l1_inval_o    <= 1'b0;
			l1_fault_o    <= ic_bus_pkg::FAULT_NONE;
			l2_rd_o       <= 1'b0;
			l2_wr_o       <= 1'b0;
			rom_rd_o      <= 1'b0;
			line_loaded_o <= 1'b0;
			bus_cyc_o     <= 1'b0;
			bus_stb_o     <= 1'b0;
			bus_cti_o     <= ic_bus_pkg::CTI_CLASSIC;
		end else begin
			// Single cycle strobes
			l1_wr_o       <= 1'b0;
			l1_inval_o    <= 1'b0;
			l2_rd_o       <= 1'b0;
			l2_wr_o       <= 1'b0;
			rom_rd_o      <= 1'b0;
			line_loaded_o <= 1'b0;

			case (state)
			ic_cache_pkg::IDLE: begin
				cnt <= '0;
				// Invalidate goes ahead of any miss
				if (inval_pend) begin
					l1_adr_o   <= inval_adr_r;
					l1_inval_o <= 1'b1;
					inval_pend <= 1'b0;
				end else if (fetch_req_i && !l1_hit_i) begin
					l1_adr_o <= fetch_line;
					l2_adr_o <= fetch_line;
					is_rom   <= rom_sel;
					// Start the ROM or L2 read right away
					rom_rd_o <= rom_sel;
					l2_rd_o  <= !rom_sel;
					state    <= ic_cache_pkg::LOOKUP;
				end
			end

			ic_cache_pkg::LOOKUP: begin
				cnt <= cnt + 3'd1;
				if (is_rom && cnt == 3'(`IC_ROM_LATENCY)) begin
					line_r     <= rom_line_i;
					l1_fault_o <= ic_bus_pkg::FAULT_NONE;
					l1_wr_o    <= 1'b1;
					cnt        <= '0;
					state      <= ic_cache_pkg::WR_WAIT;
				end else if (!is_rom && cnt == 3'(`IC_L2_LATENCY)) begin
					// L2 result is at the pipe output now
					line_r   <= l2_line_i;
					l2_hit_r <= l2_valid_i;
					cnt      <= '0;
					state    <= ic_cache_pkg::WAIT_L2;
				end
			end

			ic_cache_pkg::WAIT_L2: begin
				l1_fault_o <= ic_bus_pkg::FAULT_NONE;
				if (l2_hit_r) begin
					l1_wr_o <= 1'b1;
					state   <= ic_cache_pkg::WR_WAIT;
				end else begin
					// L2 miss, open the bus cycle at beat 0
					burst_r   <= burst_en_i;
					beat      <= '0;
					bus_cyc_o <= 1'b1;
					bus_stb_o <= 1'b1;
					bus_adr_o <= l2_adr_o[`IC_ADR_W-1:2];
					bus_cti_o <= burst_en_i ? ic_bus_pkg::CTI_INCR : ic_bus_pkg::CTI_CLASSIC;
					state     <= ic_cache_pkg::BUS_ACK;
				end
			end

			// Stays here as long as the slave holds ack low
			ic_cache_pkg::BUS_ACK: begin
				if (bus_ack_i || bus_err_i) begin
					if (bus_err_i) begin
						// Error ends the cycle, line becomes NOPs
						line_r     <= {`IC_BEATS{`IC_NOP}};
						l1_fault_o <= ic_bus_pkg::FAULT_BUS;
						bus_cyc_o  <= 1'b0;
						bus_stb_o  <= 1'b0;
						bus_cti_o  <= ic_bus_pkg::CTI_CLASSIC;
						state      <= ic_cache_pkg::BUS_DONE;
					end else begin
						line_r[beat*W +: W] <= bus_dat_i;
						beat      <= beat + 1'b1;
						bus_adr_o <= bus_adr_o + 1'b1;
						if (beat == ic_bus_pkg::beat_t'(`IC_BEATS-1)) begin
							bus_cyc_o <= 1'b0;
							bus_stb_o <= 1'b0;
							bus_cti_o <= ic_bus_pkg::CTI_CLASSIC;
							state     <= ic_cache_pkg::BUS_DONE;
						end else if (burst_r) begin
							// Last beat of the burst is flagged
							if (beat == ic_bus_pkg::beat_t'(`IC_BEATS-2))
								bus_cti_o <= ic_bus_pkg::CTI_END;
						end else begin
							bus_stb_o <= 1'b0;
							state     <= ic_cache_pkg::BUS_GAP;
						end
					end
				end
			end

			// Single beat mode, one idle cycle between strobes
			ic_cache_pkg::BUS_GAP: begin
				bus_stb_o <= 1'b1;
				state     <= ic_cache_pkg::BUS_ACK;
			end

			ic_cache_pkg::BUS_DONE: begin
				l1_wr_o <= 1'b1;
				// Faulted lines stay out of L2
				l2_wr_o       <= l1_fault_o == ic_bus_pkg::FAULT_NONE;
				line_loaded_o <= 1'b1;
				cnt           <= '0;
				state         <= ic_cache_pkg::WR_WAIT;
			end

			// Let the L1 write settle before fetch resumes
			ic_cache_pkg::WR_WAIT: begin
				cnt <= cnt + 3'd1;
				if (cnt == 3'(`IC_L1_WR_LATENCY - 1))
					state <= ic_cache_pkg::IDLE;
			end

			default: state <= ic_cache_pkg::IDLE;
			endcase

			// Latch an invalidate for the next IDLE cycle
			if (inval_i) begin
				inval_pend  <= 1'b1;
				inval_adr_r <= inval_adr_i;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/ic_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ic_subsystem (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire                        fetch_req_i,
	input  wire  ic_cache_pkg::adr_t   fetch_adr_i,
	output logic                       fetch_hit_o,
	output ic_cache_pkg::word_t        fetch_insn_o,
	output ic_bus_pkg::fault_e         fetch_fault_o,
	input  wire                        cfg_we_i,
	input  wire  [1:0]                 cfg_addr_i,
	input  wire  ic_cache_pkg::word_t  cfg_wdata_i,
	output ic_cache_pkg::word_t        cfg_rdata_o,
	output logic                       bus_cyc_o,
	output logic                       bus_stb_o,
	output ic_bus_pkg::wadr_t          bus_adr_o,
	output ic_bus_pkg::cti_t           bus_cti_o,
	input  wire                        bus_ack_i,
	input  wire                        bus_err_i,
	input  wire  ic_cache_pkg::word_t  bus_dat_i,
	output logic                       busy_o
);

	logic                l1_hit;
	logic                l1_wr;
	logic                l1_inval;
	ic_cache_pkg::adr_t  l1_adr;
	ic_cache_pkg::line_t l1_line;
	ic_bus_pkg::fault_e  l1_fault;
	logic                l2_rd;
	logic                l2_wr;
	ic_cache_pkg::adr_t  l2_adr;
	ic_cache_pkg::line_t l2_line_wr;
	logic                l2_valid;
	ic_cache_pkg::line_t l2_line_rd;
	logic                rom_rd;
	ic_cache_pkg::line_t rom_line;
	logic                burst_en;
	logic                inval;
	ic_cache_pkg::adr_t  inval_adr;
	logic                line_loaded;

	// Hit is only shown once the controller is back in IDLE
	assign fetch_hit_o = l1_hit && !busy_o;

	ic_miss_ctrl ic_miss_ctrl_i (
		.clk(clk), .rst_i(rst_i),
		.fetch_req_i(fetch_req_i), .fetch_adr_i(fetch_adr_i), .l1_hit_i(l1_hit),
		.burst_en_i(burst_en), .inval_i(inval), .inval_adr_i(inval_adr),
		.l1_wr_o(l1_wr), .l1_inval_o(l1_inval), .l1_adr_o(l1_adr),
		.l1_line_o(l1_line), .l1_fault_o(l1_fault),
		.l2_rd_o(l2_rd), .l2_wr_o(l2_wr), .l2_adr_o(l2_adr), .l2_line_o(l2_line_wr),
		.l2_valid_i(l2_valid), .l2_line_i(l2_line_rd),
		.rom_rd_o(rom_rd), .rom_line_i(rom_line),
		.line_loaded_o(line_loaded), .busy_o(busy_o),
		.bus_cyc_o(bus_cyc_o), .bus_stb_o(bus_stb_o), .bus_adr_o(bus_adr_o),
		.bus_cti_o(bus_cti_o), .bus_ack_i(bus_ack_i), .bus_err_i(bus_err_i),
		.bus_dat_i(bus_dat_i)
	);

	// Fetch reads L1 directly, controller owns the write side
	ic_l1_array ic_l1_array_i (
		.clk(clk), .rst_i(rst_i),
		.rd_adr_i(fetch_adr_i), .hit_o(l1_hit), .insn_o(fetch_insn_o),
		.fault_o(fetch_fault_o),
		.wr_i(l1_wr), .wr_adr_i(l1_adr), .wr_line_i(l1_line), .wr_fault_i(l1_fault),
		.inval_i(l1_inval)
	);

	ic_l2_array ic_l2_array_i (
		.clk(clk), .rst_i(rst_i),
		.rd_i(l2_rd), .rd_adr_i(l2_adr), .valid_o(l2_valid), .line_o(l2_line_rd),
		.wr_i(l2_wr), .wr_adr_i(l2_adr), .wr_line_i(l2_line_wr)
	);

	ic_boot_rom ic_boot_rom_i (
		.clk(clk), .rd_i(rom_rd), .adr_i(l1_adr), .line_o(rom_line)
	);

	ic_ctrl_regs ic_ctrl_regs_i (
		.clk(clk), .rst_i(rst_i),
		.cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o),
		.burst_en_o(burst_en), .inval_o(inval), .inval_adr_o(inval_adr),
		.line_loaded_i(line_loaded)
	);

endmodule

`default_nettype wire

// File: verification/tb_bus_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_mem (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       cyc_i,
	input  wire                       stb_i,
	input  wire  ic_bus_pkg::wadr_t   adr_i,
	input  wire  ic_bus_pkg::cti_t    cti_i,
	output logic                      ack_o,
	output logic                      err_o,
	output ic_cache_pkg::word_t       dat_o,
	input  wire  [1:0]                stall_i,
	input  wire                       err_en_i,
	input  wire  ic_bus_pkg::wadr_t   err_adr_i,
	output int                        cyc_cnt_o,
	output int                        beats_o,
	output int                        stb_rises_o,
	output logic [11:0]               cti_log_o,
	output logic                      seq_ok_o
);

	int                wait_cnt;
	logic              cyc_q;
	logic              stb_q;
	ic_bus_pkg::wadr_t base;

	initial begin
		ack_o       = 1'b0;
		err_o       = 1'b0;
		dat_o       = '0;
		cyc_cnt_o   = 0;
		beats_o     = 0;
		stb_rises_o = 0;
		cti_log_o   = '0;
		seq_ok_o    = 1'b1;
		wait_cnt    = 0;
		cyc_q       = 1'b0;
		stb_q       = 1'b0;
		base        = '0;
	end

	// ======================================================================
	// Responder, answers on the falling edge
	// ======================================================================
	always @(negedge clk) begin
		ack_o = 1'b0;
		err_o = 1'b0;
		if (!rst_i) begin
			// New cycle clears the per-cycle record
			if (cyc_i && !cyc_q) begin
				cyc_cnt_o++;
				beats_o     = 0;
				stb_rises_o = 0;
				cti_log_o   = '0;
				seq_ok_o    = 1'b1;
				base        = adr_i;
				wait_cnt    = 0;
			end
			if (stb_i && !stb_q)
				stb_rises_o++;
			if (cyc_i && stb_i) begin
				// Hold ack low for the programmed number of cycles
				if (wait_cnt < int'(stall_i)) begin
					wait_cnt++;
				end else begin
					wait_cnt = 0;
					// Beats must walk up from a line aligned word
					if (adr_i != ic_bus_pkg::wadr_t'(base + beats_o) || base[1:0] != 2'b00)
						seq_ok_o = 1'b0;
					cti_log_o[beats_o*3 +: 3] = cti_i;
					beats_o++;
					if (err_en_i && adr_i == err_adr_i) begin
						err_o = 1'b1;
					end else begin
						ack_o = 1'b1;
						dat_o = ic_cache_pkg::word_t'(adr_i) ^ 32'hC3C3_0000;
					end
				end
			end
			cyc_q = cyc_i;
			stb_q = stb_i;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_ic_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_params.svh"

module tb_ic_subsystem;

	// Upper bound on fetches in the run, sets the watchdog
	localparam int NUM_REQ     = 64;
	localparam int TIMEOUT_CYC = 400 * NUM_REQ;

	logic                clk;
	logic                rst_i;
	logic                fetch_req_i;
	ic_cache_pkg::adr_t  fetch_adr_i;
	logic                fetch_hit_o;
	ic_cache_pkg::word_t fetch_insn_o;
	ic_bus_pkg::fault_e  fetch_fault_o;
	logic                cfg_we_i;
	logic [1:0]          cfg_addr_i;
	ic_cache_pkg::word_t cfg_wdata_i;
	ic_cache_pkg::word_t cfg_rdata_o;
	logic                bus_cyc_o;
	logic                bus_stb_o;
	ic_bus_pkg::wadr_t   bus_adr_o;
	ic_bus_pkg::cti_t    bus_cti_o;
	logic                bus_ack_i;
	logic                bus_err_i;
	ic_cache_pkg::word_t bus_dat_i;
	logic                busy_o;

	// Responder control and per-cycle record
	logic              err_en;
	ic_bus_pkg::wadr_t err_adr;
	logic [1:0]        stall;
	int                cyc_cnt;
	int                beats;
	int                stb_rises;
	logic [11:0]       cti_log;
	logic              seq_ok;

	// Shadow tables of both caches
	logic               l1_valid [`IC_L1_LINES];
	logic [23:0]        l1_tag   [`IC_L1_LINES];
	ic_bus_pkg::fault_e l1_fault [`IC_L1_LINES];
	logic               l2_valid [`IC_L2_LINES];
	logic [22:0]        l2_tag   [`IC_L2_LINES];
	logic               exp_burst;
	int                 exp_loads;

	ic_subsystem ic_subsystem_i (.*);

	tb_bus_mem bus_mem_i (
		.clk(clk), .rst_i(rst_i), .cyc_i(bus_cyc_o), .stb_i(bus_stb_o),
		.adr_i(bus_adr_o), .cti_i(bus_cti_o),
		.ack_o(bus_ack_i), .err_o(bus_err_i), .dat_o(bus_dat_i),
		.stall_i(stall), .err_en_i(err_en), .err_adr_i(err_adr),
		.cyc_cnt_o(cyc_cnt), .beats_o(beats), .stb_rises_o(stb_rises),
		.cti_log_o(cti_log), .seq_ok_o(seq_ok)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_fail(input string msg);
		stop_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
	endtask

	// Content rules of ROM and memory, per word address
	function automatic ic_cache_pkg::word_t rom_word(input ic_cache_pkg::adr_t a);
		return ic_cache_pkg::word_t'(a[31:2]) ^ 32'h5A5A_0000;
	endfunction

	function automatic ic_cache_pkg::word_t mem_word(input ic_cache_pkg::adr_t a);
		return ic_cache_pkg::word_t'(a[31:2]) ^ 32'hC3C3_0000;
	endfunction

	// ======================================================================
	// Fetch with model prediction and checks
	// ======================================================================
	task automatic do_fetch(input ic_cache_pkg::adr_t a);
		int                  i1;
		int                  i2;
		int                  n;
		int                  cyc0;
		int                  exp_beats;
		logic                hit;
		logic                rom;
		logic                l2hit;
		logic                on_bus;
		logic                bad;
		ic_cache_pkg::word_t exp_word;
		ic_bus_pkg::fault_e  exp_fault;
		i1     = int'(a[7:4]);
		i2     = int'(a[8:4]);
		hit    = l1_valid[i1] && l1_tag[i1] == a[31:8];
		rom    = a[31:20] == `IC_ROM_BASE_HI;
		l2hit  = !rom && l2_valid[i2] && l2_tag[i2] == a[31:9];
		on_bus = !hit && !rom && !l2hit;
		// Error only if the marked word lies in this line
		bad       = on_bus && err_en && err_adr[29:2] == a[31:4];
		exp_beats = bad ? int'(err_adr[1:0]) + 1 : `IC_BEATS;
		exp_fault = hit ? l1_fault[i1] : (bad ? ic_bus_pkg::FAULT_BUS : ic_bus_pkg::FAULT_NONE);
		if (exp_fault == ic_bus_pkg::FAULT_BUS)
			exp_word = `IC_NOP;
		else
			exp_word = rom ? rom_word(a) : mem_word(a);
		cyc0 = cyc_cnt;
		@(negedge clk);
		stall       = 2'($urandom_range(0, 3));
		fetch_req_i = 1'b1;
		fetch_adr_i = a;
		#1;
		assert (fetch_hit_o == hit)
			else check_fail($sformatf("hit %0b at %h, expected %0b", fetch_hit_o, a, hit));
		// Controller sits in IDLE between fetches
		assert (!busy_o) else check_fail($sformatf("busy high before fetch of %h", a));
		n = 0;
		while (!fetch_hit_o && n < 400) begin
			@(negedge clk);
			#1;
			n++;
			// A miss leaves IDLE on the first edge
			if (n == 1) begin
				assert (busy_o) else check_fail($sformatf("busy low during miss of %h", a));
			end
		end
		assert (fetch_hit_o) else stop_run($sformatf("Fetch of %h never completed", a));
		assert (fetch_insn_o == exp_word)
			else check_fail($sformatf("word %h at %h, expected %h", fetch_insn_o, a, exp_word));
		assert (fetch_fault_o == exp_fault)
			else check_fail($sformatf("fault %0d at %h, expected %0d", fetch_fault_o, a,
				exp_fault));
		assert (cyc_cnt == cyc0 + int'(on_bus))
			else check_fail($sformatf("%0d bus cycles for %h", cyc_cnt - cyc0, a));
		if (on_bus) begin
			assert (seq_ok) else check_fail($sformatf("beat addresses wrong for %h", a));
			assert (beats == exp_beats)
				else check_fail($sformatf("%0d beats, expected %0d", beats, exp_beats));
			// Burst keeps stb high, single mode pulses it per beat
			assert (stb_rises == (exp_burst ? 1 : exp_beats))
				else check_fail($sformatf("%0d stb pulses, burst %0b", stb_rises, exp_burst));
			if (!bad) begin
				assert (cti_log == (exp_burst ? {ic_bus_pkg::CTI_END, ic_bus_pkg::CTI_INCR,
					ic_bus_pkg::CTI_INCR, ic_bus_pkg::CTI_INCR} : 12'h000))
					else check_fail($sformatf("cti sequence %h, burst %0b", cti_log, exp_burst));
			end
		end
		// Model update
		if (!hit) begin
			l1_valid[i1] = 1'b1;
			l1_tag[i1]   = a[31:8];
			l1_fault[i1] = exp_fault;
		end
		if (on_bus) begin
			exp_loads++;
			if (!bad) begin
				l2_valid[i2] = 1'b1;
				l2_tag[i2]   = a[31:9];
			end
		end
		@(negedge clk);
		fetch_req_i = 1'b0;
	endtask

	task automatic cfg_write(input logic [1:0] addr, input ic_cache_pkg::word_t data);
		@(negedge clk);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = data;
		@(negedge clk);
		cfg_we_i = 1'b0;
		// Invalidate passes the register, the pending latch and the L1 write
		repeat (4) @(negedge clk);
		if (addr == 2'd0)
			exp_burst = data[0];
		if (addr == 2'd1 && l1_tag[data[7:4]] == data[31:8])
			l1_valid[data[7:4]] = 1'b0;
	endtask

	task automatic cfg_check(input logic [1:0] addr, input ic_cache_pkg::word_t exp);
		@(negedge clk);
		cfg_addr_i = addr;
		#1;
		assert (cfg_rdata_o == exp)
			else check_fail($sformatf("register %0d reads %h, expected %h", addr, cfg_rdata_o,
				exp));
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial begin
		ic_cache_pkg::adr_t a;
		ic_cache_pkg::adr_t b;
		int                 k;
		void'($urandom(32'hf881_bbbf));
		rst_i       = 1'b1;
		fetch_req_i = 1'b0;
		fetch_adr_i = '0;
		cfg_we_i    = 1'b0;
		cfg_addr_i  = 2'd0;
		cfg_wdata_i = '0;
		err_en      = 1'b0;
		err_adr     = '0;
		stall       = 2'd0;
		exp_burst   = 1'b1;
		exp_loads   = 0;
		for (k = 0; k < `IC_L1_LINES; k++) begin
			l1_valid[k] = 1'b0;
			l1_tag[k]   = '0;
			l1_fault[k] = ic_bus_pkg::FAULT_NONE;
		end
		for (k = 0; k < `IC_L2_LINES; k++) begin
			l2_valid[k] = 1'b0;
			l2_tag[k]   = '0;
		end
		repeat (10) @(negedge clk);
		rst_i = 1'b0;

		// Boot ROM line, then a plain hit
		a = 32'hFFF0_0000 | ($urandom & 32'h000F_FFFC);
		do_fetch(a);
		do_fetch(a);
		// Burst miss and repeat
		a = $urandom & 32'h00FF_FFFC;
		do_fetch(a);
		do_fetch(a);
		// L1 conflict only, refetch from L2
		do_fetch(a ^ 32'h0000_0100);
		do_fetch(a);
		// Conflict in L1 and L2 alike
		do_fetch(a ^ 32'h0000_0200);
		do_fetch(a);

		// Bus error on one word of a line
		b = 32'h0100_0000 | ($urandom & 32'h00FF_FFFC);
		@(negedge clk);
		err_en  = 1'b1;
		err_adr = {b[31:4], 2'($urandom)};
		do_fetch(b);
		cfg_write(2'd1, b);
		@(negedge clk);
		err_en = 1'b0;
		do_fetch(b);

		// Single beat cycles
		cfg_write(2'd0, 32'd0);
		cfg_check(2'd0, 32'd0);
		for (k = 0; k < 4; k++)
			do_fetch(32'h0200_0000 | ($urandom & 32'h00FF_FFFC));
		cfg_check(2'd2, exp_loads);

		// Invalidate with another tag leaves the line alone
		a = 32'h0300_0000 | ($urandom & 32'h00FF_FFFC);
		do_fetch(a);
		cfg_write(2'd1, a ^ 32'h0000_1000);
		do_fetch(a);
		cfg_write(2'd1, a);
		do_fetch(a);

		// Random mix over a small address window
		for (k = 0; k < 40; k++) begin
			case ($urandom_range(0, 9))
			0: cfg_write(2'd0, 32'($urandom_range(0, 1)));
			1: cfg_write(2'd1, 32'h0001_0000 | ($urandom & 32'h0000_0FFC));
			2: do_fetch(32'hFFF0_0000 | ($urandom & 32'h0000_0FFC));
			default: do_fetch(32'h0001_0000 | ($urandom & 32'h0000_0FFC));
			endcase
		end
		cfg_check(2'd2, exp_loads);
		$display("All checks passed");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		stop_run("Timeout: the fetch sequence did not finish in time");
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
hdl/ic_cache_pkg.sv
hdl/ic_bus_pkg.sv
hdl/ic_boot_rom.sv
hdl/ic_l1_array.sv
hdl/ic_l2_array.sv
hdl/ic_ctrl_regs.sv
hdl/ic_miss_ctrl.sv
hdl/ic_subsystem.sv
verification/tb_bus_mem.sv
verification/tb_ic_subsystem.sv
